/* Makefile */
SIM := obj_dir/Vtb_qs

.PHONY: all run clean

all: run

$(SIM): flist.f $(wildcard src/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --top-module tb_qs -f flist.f -o Vtb_qs

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

/* flist.f */
src/qs_pkg.sv
src/qs_enqueue.sv
src/qs_bank.sv
src/qs_sort.sv
src/qs_dequeue.sv
src/qs_top.sv
verif/tb_qs.sv

/* src/qs_bank.sv */
// Sorter bank
// Single-port word memory plus its lifecycle state, stored length and
// error flag. The lifecycle state picks which controller owns the port
`timescale 1ns/1ns
`default_nettype none

module qs_bank #(
  parameter int BANK_ID = 0
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  // Enqueue client
  input  wire qs_pkg::bank_id_t      enq_bank,
  input  wire logic                  enq_en,
  input  wire qs_pkg::addr_t         enq_addr,
  input  wire qs_pkg::word_t         enq_din,
  input  wire logic                  load_start,
  input  wire logic                  load_done,
  input  wire qs_pkg::addr_t         load_last,
  input  wire logic                  load_ovf,
  // Sort client
  input  wire qs_pkg::bank_id_t      sort_bank,
  input  wire logic                  sort_en,
  input  wire logic                  sort_wen,
  input  wire qs_pkg::addr_t         sort_addr,
  input  wire qs_pkg::word_t         sort_din,
  input  wire logic                  sort_start,
  input  wire logic                  sort_done,
  // Dequeue client
  input  wire qs_pkg::bank_id_t      deq_bank,
  input  wire logic                  deq_en,
  input  wire qs_pkg::addr_t         deq_addr,
  input  wire logic                  unload_start,
  input  wire logic                  unload_done,
  output qs_pkg::bank_status_t       status,
  output qs_pkg::addr_t              last,
  output logic                       err,
  output qs_pkg::word_t              dout
);

  localparam qs_pkg::bank_id_t ID = qs_pkg::bank_id_t'(BANK_ID);

  qs_pkg::word_t mem [qs_pkg::N_WORDS];
  logic          enq_hit;
  logic          sort_hit;
  logic          deq_hit;
  logic          close_hit;
  logic          mem_en;
  logic          mem_wen;
  qs_pkg::addr_t mem_addr;
  qs_pkg::word_t mem_din;

  // Which clients point here
  assign enq_hit  = (enq_bank == ID);
  assign sort_hit = (sort_bank == ID);
  assign deq_hit  = (deq_bank == ID);

  // Packet close while enqueue owns the bank
  assign close_hit = load_done & enq_hit &
                     ((status == qs_pkg::BANK_IDLE) | (status == qs_pkg::BANK_LOADING));

  // Port owner follows lifecycle
  always_comb begin
    mem_en   = 1'b0;
    mem_wen  = 1'b0;
    mem_addr = enq_addr;
    mem_din  = enq_din;
    case (status)
      qs_pkg::BANK_IDLE, qs_pkg::BANK_LOADING: begin
        // Enqueue only ever writes
        mem_en  = enq_en & enq_hit;
        mem_wen = 1'b1;
      end
      qs_pkg::BANK_READY, qs_pkg::BANK_SORTING: begin
        mem_en   = sort_en & sort_hit;
        mem_wen  = sort_wen;
        mem_addr = sort_addr;
        mem_din  = sort_din;
      end
      default: begin
        // Dequeue only ever reads
        mem_en   = deq_en & deq_hit;
        mem_addr = deq_addr;
      end
    endcase
  end

  // Lifecycle, one step per matching pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      status <= qs_pkg::BANK_IDLE;
      err    <= 1'b0;
    end else begin
      case (status)
        qs_pkg::BANK_IDLE:
          if (load_start && enq_hit) begin
            // Single-beat packet closes on its opening beat
            status <= load_done ? qs_pkg::BANK_READY : qs_pkg::BANK_LOADING;
          end
        qs_pkg::BANK_LOADING:
          if (load_done && enq_hit) status <= qs_pkg::BANK_READY;
        qs_pkg::BANK_READY:
          if (sort_start && sort_hit) begin
            status <= sort_done ? qs_pkg::BANK_SORTED : qs_pkg::BANK_SORTING;
          end
        qs_pkg::BANK_SORTING:
          if (sort_done && sort_hit) status <= qs_pkg::BANK_SORTED;
        qs_pkg::BANK_SORTED:
          if (unload_start && deq_hit) begin
            status <= unload_done ? qs_pkg::BANK_IDLE : qs_pkg::BANK_UNLOADING;
          end
        qs_pkg::BANK_UNLOADING:
          if (unload_done && deq_hit) status <= qs_pkg::BANK_IDLE;
        default:
          status <= qs_pkg::BANK_IDLE;
      endcase
      // Overflow marks the whole packet
      if (close_hit) err <= load_ovf;
    end
  end

  // Stored length of current packet
  always_ff @(posedge clk) begin
    if (close_hit) last <= load_last;
  end

  // Single port, read data one cycle after enable
  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_wen) begin
        mem[mem_addr] <= mem_din;
      end else begin
        dout <= mem[mem_addr];
      end
    end
  end

endmodule

`default_nettype wire

/* src/qs_dequeue.sv */
// Dequeue controller
// Drains sorted banks in round-robin order. Each read carries its
// framing one stage, then the output registers take the bank data
`timescale 1ns/1ns
`default_nettype none

module qs_dequeue (
  input  wire logic                                         clk,
  input  wire logic                                         rst,
  input  wire qs_pkg::bank_status_t [qs_pkg::BANKS_N-1:0]   bank_status,
  input  wire qs_pkg::addr_t [qs_pkg::BANKS_N-1:0]          bank_last,
  input  wire logic [qs_pkg::BANKS_N-1:0]                   bank_err,
  input  wire qs_pkg::word_t [qs_pkg::BANKS_N-1:0]          bank_dout,
  output qs_pkg::bank_id_t                                  deq_bank,
  output logic                                              deq_en,
  output qs_pkg::addr_t                                     deq_addr,
  output logic                                              unload_start,
  output logic                                              unload_done,
  output logic                                              out_vld,
  output logic                                              out_sop,
  output logic                                              out_eop,
  output logic                                              out_err,
  output qs_pkg::word_t                                     out_dat
);

  typedef enum logic {
    DEQ_IDLE,
    DEQ_EMIT
  } deq_state_t;

  deq_state_t       state;
  qs_pkg::bank_id_t bank;
  qs_pkg::addr_t    idx;
  logic             last_rd;
  // Read stage framing
  logic             s1_vld;
  logic             s1_sop;
  logic             s1_eop;
  logic             s1_err;
  qs_pkg::bank_id_t s1_bank;

  // Open a packet as soon as its bank is sorted
  assign unload_start = (state == DEQ_IDLE) &&
                        (bank_status[bank] == qs_pkg::BANK_SORTED);

  // One read per cycle until the last stored word
  assign deq_bank    = bank;
  assign deq_en      = unload_start | (state == DEQ_EMIT);
  assign deq_addr    = idx;
  assign last_rd     = deq_en && (idx == bank_last[bank]);
  assign unload_done = last_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= DEQ_IDLE;
      bank    <= '0;
      idx     <= '0;
      s1_vld  <= 1'b0;
      out_vld <= 1'b0;
    end else begin
      s1_vld  <= deq_en;
      out_vld <= s1_vld;
      if (deq_en) begin
        if (last_rd) begin
          state <= DEQ_IDLE;
          bank  <= qs_pkg::next_bank(bank);
          idx   <= '0;
        end else begin
          state <= DEQ_EMIT;
          idx   <= idx + 1'b1;
        end
      end
    end
  end

  // Framing travels with the read
  always_ff @(posedge clk) begin
    if (deq_en) begin
      s1_sop  <= unload_start;
      s1_eop  <= last_rd;
      s1_err  <= bank_err[bank];
      s1_bank <= bank;
    end
  end

  // Output beat with the returned word
  always_ff @(posedge clk) begin
    if (s1_vld) begin
      out_sop <= s1_sop;
      out_eop <= s1_eop;
      out_err <= s1_err;
      out_dat <= bank_dout[s1_bank];
    end
  end

endmodule

`default_nettype wire

/* src/qs_enqueue.sv */
// Enqueue controller
// Loads input packets into the banks in round-robin order. Words beyond
// the bank depth are accepted but dropped, and the packet is flagged
`timescale 1ns/1ns
`default_nettype none

module qs_enqueue (
  input  wire logic                                         clk,
  input  wire logic                                         rst,
  input  wire logic                                         in_vld,
  input  wire logic                                         in_sop,
  input  wire logic                                         in_eop,
  input  wire qs_pkg::word_t                                in_dat,
  input  wire qs_pkg::bank_status_t [qs_pkg::BANKS_N-1:0]   bank_status,
  output logic                                              in_rdy,
  output qs_pkg::bank_id_t                                  enq_bank,
  output logic                                              enq_en,
  output qs_pkg::addr_t                                     enq_addr,
  output qs_pkg::word_t                                     enq_din,
  output logic                                              load_start,
  output logic                                              load_done,
  output qs_pkg::addr_t                                     load_last,
  output logic                                              load_ovf
);

  typedef enum logic {
    ENQ_IDLE,
    ENQ_LOAD
  } enq_state_t;

  enq_state_t           state;
  qs_pkg::bank_id_t     bank;
  qs_pkg::addr_t        cnt;
  logic                 full;
  qs_pkg::bank_status_t cur_status;
  logic                 accept;
  logic                 active;

  // Status of the bank being filled
  assign cur_status = bank_status[bank];

  // Idle bank when waiting, own loading bank mid-packet
  assign in_rdy = (state == ENQ_IDLE) ? (cur_status == qs_pkg::BANK_IDLE)
                                      : (cur_status == qs_pkg::BANK_LOADING);
  assign accept = in_vld & in_rdy;

  // Stray beats outside a packet are swallowed
  assign load_start = accept & in_sop & (state == ENQ_IDLE);
  assign active     = load_start | (accept & (state == ENQ_LOAD));

  // Write straight from the beat, nothing past the last slot
  assign enq_bank = bank;
  assign enq_en   = active & ~full;
  assign enq_addr = cnt;
  assign enq_din  = in_dat;

  // Close reports last stored slot
  assign load_done = active & in_eop;
  assign load_last = full ? qs_pkg::addr_t'(qs_pkg::N_WORDS - 1) : cnt;
  // Any beat seen once full is an overflow beat
  assign load_ovf  = full;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ENQ_IDLE;
      bank  <= '0;
      cnt   <= '0;
      full  <= 1'b0;
    end else if (active) begin
      if (in_eop) begin
        // Packet closed, hand over to next bank
        state <= ENQ_IDLE;
        bank  <= qs_pkg::next_bank(bank);
        cnt   <= '0;
        full  <= 1'b0;
      end else begin
        state <= ENQ_LOAD;
        if (!full) begin
          cnt <= cnt + 1'b1;
          // Last slot just written
          if (cnt == qs_pkg::addr_t'(qs_pkg::N_WORDS - 1)) begin
            full <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/qs_pkg.sv */
// Banked packet sorter shared definitions
// Sizes, vector types and the bank lifecycle encoding used by every block
`default_nettype none

package qs_pkg;

  // Bank depth, also the largest packet kept
  localparam int N_WORDS = 16;
  // Width of one data word
  localparam int WORD_W = 16;
  // Number of banks in rotation
  localparam int BANKS_N = 2;

  // Derived widths
  localparam int ADDR_W = $clog2(N_WORDS);
  // Bank index keeps at least one bit
  localparam int BANK_W = (BANKS_N > 1) ? $clog2(BANKS_N) : 1;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BANK_W-1:0] bank_id_t;

  // Bank lifecycle
  typedef enum logic [2:0] {
    BANK_IDLE      = 3'd0,
    BANK_LOADING   = 3'd1,
    BANK_READY     = 3'd2,
    BANK_SORTING   = 3'd3,
    BANK_SORTED    = 3'd4,
    BANK_UNLOADING = 3'd5
  } bank_status_t;

  // Round-robin successor of a bank index
  function automatic bank_id_t next_bank(bank_id_t id);
    return (id == bank_id_t'(BANKS_N - 1)) ? '0 : bank_id_t'(id + 1'b1);
  endfunction

endpackage

`default_nettype wire

/* src/qs_sort.sv */
// Sort engine
// Claims each ready bank in turn and sorts it in place into ascending
// order with repeated passes of neighbor swaps through the bank port.
// The larger word of each pair is carried into the next compare
`timescale 1ns/1ns
`default_nettype none

module qs_sort (
  input  wire logic                                         clk,
  input  wire logic                                         rst,
  input  wire qs_pkg::bank_status_t [qs_pkg::BANKS_N-1:0]   bank_status,
  input  wire qs_pkg::addr_t [qs_pkg::BANKS_N-1:0]          bank_last,
  input  wire qs_pkg::word_t [qs_pkg::BANKS_N-1:0]          bank_dout,
  output qs_pkg::bank_id_t                                  sort_bank,
  output logic                                              sort_en,
  output logic                                              sort_wen,
  output qs_pkg::addr_t                                     sort_addr,
  output qs_pkg::word_t                                     sort_din,
  output logic                                              sort_start,
  output logic                                              sort_done
);

  typedef enum logic [2:0] {
    SRT_IDLE,
    SRT_RD0,
    SRT_RD1,
    SRT_CMP,
    SRT_WR1
  } sort_state_t;

  sort_state_t      state;
  qs_pkg::bank_id_t bank;
  // First address of the current pair
  qs_pkg::addr_t    idx;
  qs_pkg::addr_t    idx_nxt;
  logic             swapped;
  // Word held for slot idx
  qs_pkg::word_t    a_r;
  qs_pkg::word_t    b;
  logic             swap;
  logic             pass_end;

  assign b        = bank_dout[bank];
  assign idx_nxt  = idx + 1'b1;
  assign pass_end = (idx_nxt == bank_last[bank]);
  // Pair out of order
  assign swap     = (state == SRT_CMP) && (a_r > b);

  assign sort_bank = bank;

  always_comb begin
    sort_en    = 1'b0;
    sort_wen   = 1'b0;
    sort_addr  = idx;
    sort_din   = b;
    sort_start = 1'b0;
    sort_done  = 1'b0;
    case (state)
      SRT_IDLE:
        if (bank_status[bank] == qs_pkg::BANK_READY) begin
          sort_start = 1'b1;
          // One word is already sorted
          sort_done  = (bank_last[bank] == '0);
        end
      SRT_RD0: begin
        sort_en   = 1'b1;
        sort_addr = '0;
      end
      SRT_RD1: begin
        sort_en   = 1'b1;
        sort_addr = idx_nxt;
      end
      SRT_CMP:
        if (swap) begin
          // Smaller word down to idx
          sort_en  = 1'b1;
          sort_wen = 1'b1;
        end else if (pass_end && !swapped) begin
          sort_done = 1'b1;
        end
      SRT_WR1: begin
        // Larger word up to idx+1
        sort_en   = 1'b1;
        sort_wen  = 1'b1;
        sort_addr = idx_nxt;
        sort_din  = a_r;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= SRT_IDLE;
      bank    <= '0;
      idx     <= '0;
      swapped <= 1'b0;
    end else begin
      case (state)
        SRT_IDLE:
          if (sort_start) begin
            if (sort_done) begin
              bank <= qs_pkg::next_bank(bank);
            end else begin
              state   <= SRT_RD0;
              idx     <= '0;
              swapped <= 1'b0;
            end
          end
        SRT_RD0: state <= SRT_RD1;
        SRT_RD1: state <= SRT_CMP;
        SRT_CMP, SRT_WR1:
          if (swap) begin
            swapped <= 1'b1;
            state   <= SRT_WR1;
          end else if (sort_done) begin
            // Clean pass, bank finished
            state <= SRT_IDLE;
            bank  <= qs_pkg::next_bank(bank);
          end else if (pass_end) begin
            // Another pass needed
            state   <= SRT_RD0;
            idx     <= '0;
            swapped <= 1'b0;
          end else begin
            state <= SRT_RD1;
            idx   <= idx_nxt;
          end
        default: state <= SRT_IDLE;
      endcase
    end
  end

  // Held word tracks the larger of each pair
  always_ff @(posedge clk) begin
    if (state == SRT_RD1 && idx == '0) begin
      // Word 0 returns at pass start
      a_r <= b;
    end else if (state == SRT_CMP && !swap) begin
      a_r <= b;
    end
  end

endmodule

`default_nettype wire

/* src/qs_top.sv */
// Banked packet sorter top level
// Enqueue, sort and dequeue controllers around a ring of bank memories
`timescale 1ns/1ns
`default_nettype none

module qs_top (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           in_vld,
  input  wire logic           in_sop,
  input  wire logic           in_eop,
  input  wire qs_pkg::word_t  in_dat,
  output logic                in_rdy,
  output logic                out_vld,
  output logic                out_sop,
  output logic                out_eop,
  output logic                out_err,
  output qs_pkg::word_t       out_dat
);

  // Enqueue side
  qs_pkg::bank_id_t enq_bank;
  logic             enq_en;
  qs_pkg::addr_t    enq_addr;
  qs_pkg::word_t    enq_din;
  logic             load_start;
  logic             load_done;
  qs_pkg::addr_t    load_last;
  logic             load_ovf;

  // Sort side
  qs_pkg::bank_id_t sort_bank;
  logic             sort_en;
  logic             sort_wen;
  qs_pkg::addr_t    sort_addr;
  qs_pkg::word_t    sort_din;
  logic             sort_start;
  logic             sort_done;

  // Dequeue side
  qs_pkg::bank_id_t deq_bank;
  logic             deq_en;
  qs_pkg::addr_t    deq_addr;
  logic             unload_start;
  logic             unload_done;

  // Per-bank returns
  qs_pkg::bank_status_t [qs_pkg::BANKS_N-1:0] bank_status;
  qs_pkg::addr_t [qs_pkg::BANKS_N-1:0]        bank_last;
  logic [qs_pkg::BANKS_N-1:0]                 bank_err;
  qs_pkg::word_t [qs_pkg::BANKS_N-1:0]        bank_dout;

  qs_enqueue u_enqueue (
    .clk         (clk),
    .rst         (rst),
    .in_vld      (in_vld),
    .in_sop      (in_sop),
    .in_eop      (in_eop),
    .in_dat      (in_dat),
    .bank_status (bank_status),
    .in_rdy      (in_rdy),
    .enq_bank    (enq_bank),
    .enq_en      (enq_en),
    .enq_addr    (enq_addr),
    .enq_din     (enq_din),
    .load_start  (load_start),
    .load_done   (load_done),
    .load_last   (load_last),
    .load_ovf    (load_ovf)
  );

  qs_sort u_sort (
    .clk         (clk),
    .rst         (rst),
    .bank_status (bank_status),
    .bank_last   (bank_last),
    .bank_dout   (bank_dout),
    .sort_bank   (sort_bank),
    .sort_en     (sort_en),
    .sort_wen    (sort_wen),
    .sort_addr   (sort_addr),
    .sort_din    (sort_din),
    .sort_start  (sort_start),
    .sort_done   (sort_done)
  );

  qs_dequeue u_dequeue (
    .clk          (clk),
    .rst          (rst),
    .bank_status  (bank_status),
    .bank_last    (bank_last),
    .bank_err     (bank_err),
    .bank_dout    (bank_dout),
    .deq_bank     (deq_bank),
    .deq_en       (deq_en),
    .deq_addr     (deq_addr),
    .unload_start (unload_start),
    .unload_done  (unload_done),
    .out_vld      (out_vld),
    .out_sop      (out_sop),
    .out_eop      (out_eop),
    .out_err      (out_err),
    .out_dat      (out_dat)
  );

  // Bank ring, each bank decodes its own index
  for (genvar g = 0; g < qs_pkg::BANKS_N; g++) begin : g_bank
    qs_bank #(
      .BANK_ID (g)
    ) u_bank (
      .clk          (clk),
      .rst          (rst),
      .enq_bank     (enq_bank),
      .enq_en       (enq_en),
      .enq_addr     (enq_addr),
      .enq_din      (enq_din),
      .load_start   (load_start),
      .load_done    (load_done),
      .load_last    (load_last),
      .load_ovf     (load_ovf),
      .sort_bank    (sort_bank),
      .sort_en      (sort_en),
      .sort_wen     (sort_wen),
      .sort_addr    (sort_addr),
      .sort_din     (sort_din),
      .sort_start   (sort_start),
      .sort_done    (sort_done),
      .deq_bank     (deq_bank),
      .deq_en       (deq_en),
      .deq_addr     (deq_addr),
      .unload_start (unload_start),
      .unload_done  (unload_done),
      .status       (bank_status[g]),
      .last         (bank_last[g]),
      .err          (bank_err[g]),
      .dout         (bank_dout[g])
    );
  end

endmodule

`default_nettype wire

/* verif/tb_qs.sv */
// Banked packet sorter testbench
// Directed tests drive framed packets into the sorter, while an output
// monitor checks each beat against a reference sort model
`timescale 1ns/1ns
`default_nettype none

module tb_qs;

  // Worst case cycles per packet grow with the square of the bank depth
  localparam int PKT_CYCLES = qs_pkg::N_WORDS * qs_pkg::N_WORDS * 4 + 100;
  localparam int N_PKTS = 9;
  localparam int WATCHDOG_CYCLES = N_PKTS * PKT_CYCLES + 500;

  logic          clk = 1'b0;
  logic          rst;
  logic          in_vld;
  logic          in_sop;
  logic          in_eop;
  qs_pkg::word_t in_dat;
  logic          in_rdy;
  logic          out_vld;
  logic          out_sop;
  logic          out_eop;
  logic          out_err;
  qs_pkg::word_t out_dat;

  // Reference beats still owed by the DUT
  qs_pkg::word_t exp_word[$];
  logic          exp_sop[$];
  logic          exp_eop[$];
  logic          exp_err[$];
  // Packet under construction for the driver
  qs_pkg::word_t pkt_words[$];

  int            errors = 0;
  int            n_checks = 0;
  logic          in_burst = 1'b0;
  logic          saw_stall = 1'b0;

  qs_top DUT (
    .clk     (clk),
    .rst     (rst),
    .in_vld  (in_vld),
    .in_sop  (in_sop),
    .in_eop  (in_eop),
    .in_dat  (in_dat),
    .in_rdy  (in_rdy),
    .out_vld (out_vld),
    .out_sop (out_sop),
    .out_eop (out_eop),
    .out_err (out_err),
    .out_dat (out_dat)
  );

  always #20 clk = ~clk;

  task automatic check_word(input string what, input qs_pkg::word_t got,
                            input qs_pkg::word_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      $display("Error at %0t ns: flag %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      $display("Error at %0t ns: level %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // Reference model keeps the first N_WORDS words sorted ascending
  // and flags the packet on overflow
  task automatic expect_packet();
    qs_pkg::word_t kept[$];
    qs_pkg::word_t key;
    logic          ovf;
    int            i;
    int            j;
    ovf = (pkt_words.size() > qs_pkg::N_WORDS);
    for (i = 0; i < pkt_words.size() && i < qs_pkg::N_WORDS; i++) begin
      kept.push_back(pkt_words[i]);
    end
    // Insertion sort
    for (i = 1; i < kept.size(); i++) begin
      key = kept[i];
      j = i - 1;
      while (j >= 0 && kept[j] > key) begin
        kept[j + 1] = kept[j];
        j--;
      end
      kept[j + 1] = key;
    end
    for (i = 0; i < kept.size(); i++) begin
      exp_word.push_back(kept[i]);
      exp_sop.push_back(i == 0);
      exp_eop.push_back(i == kept.size() - 1);
      exp_err.push_back(ovf);
    end
  endtask

  // Starts and ends 5 ns after a rising edge
  task automatic send_packet();
    int i;
    expect_packet();
    for (i = 0; i < pkt_words.size(); i++) begin
      in_vld = 1'b1;
      in_sop = (i == 0);
      in_eop = (i == pkt_words.size() - 1);
      in_dat = pkt_words[i];
      // in_rdy only moves on the rising edge
      @(negedge clk);
      while (!in_rdy) begin
        saw_stall = 1'b1;
        @(negedge clk);
      end
      @(posedge clk);
      #5;
    end
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
  endtask

  // Wait for every owed beat to leave within a per-packet bound
  task automatic wait_drained(input int n_pkts);
    int cycles;
    cycles = 0;
    while ((exp_word.size() != 0 || in_burst) && cycles < n_pkts * PKT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_word.size() != 0 || in_burst) begin
      $display("Output packets did not drain within %0d cycles at %0t ns",
               n_pkts * PKT_CYCLES, $time);
      errors++;
    end
    repeat (3) @(posedge clk);
    #5;
    // All banks idle again
    check_status("in_rdy after drain", in_rdy, 1'b1);
  endtask

  // One output beat against the head of the expected queue
  task automatic check_beat();
    if (exp_word.size() == 0) begin
      $display("Unexpected output beat %h at %0t ns with no packet pending",
               out_dat, $time);
      errors++;
    end else begin
      check_word("out_dat", out_dat, exp_word.pop_front());
      check_flag("out_sop", out_sop, exp_sop.pop_front());
      check_flag("out_eop", out_eop, exp_eop.pop_front());
      check_flag("out_err", out_err, exp_err.pop_front());
    end
    in_burst = !out_eop;
  endtask

  // Output monitor at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (out_vld) begin
        check_beat();
      end else if (in_burst) begin
        $display("Output burst broken at %0t ns: out_vld dropped before eop", $time);
        errors++;
        in_burst = 1'b0;
      end
    end
  end

  task automatic idle_after_reset();
    check_status("in_rdy after reset", in_rdy, 1'b1);
    repeat (20) begin
      @(negedge clk);
      check_status("out_vld while idle", out_vld, 1'b0);
    end
    @(posedge clk);
    #5;
  endtask

  task automatic seven_word_packet();
    pkt_words = '{16'h0042, 16'h0007, 16'hffff, 16'h0000, 16'h1234, 16'h0007, 16'h8000};
    send_packet();
    wait_drained(1);
  endtask

  task automatic single_word_packet();
    pkt_words = '{16'hbeef};
    send_packet();
    wait_drained(1);
  endtask

  // Last 4 of 20 words are dropped and the packet is flagged
  task automatic long_packet_overflow();
    int i;
    pkt_words.delete();
    for (i = 0; i < 20; i++) begin
      pkt_words.push_back(qs_pkg::word_t'($urandom));
    end
    send_packet();
    wait_drained(1);
  endtask

  task automatic random_back_to_back();
    int p;
    int i;
    int len;
    saw_stall = 1'b0;
    for (p = 0; p < 6; p++) begin
      len = $urandom_range(16, 1);
      pkt_words.delete();
      for (i = 0; i < len; i++) begin
        pkt_words.push_back(qs_pkg::word_t'($urandom));
      end
      send_packet();
    end
    wait_drained(6);
    // Both banks busy must have held off input
    check_status("in_rdy low seen", saw_stall, 1'b1);
  endtask

  initial begin
    void'($urandom(32'hf3de));
    rst    = 1'b1;
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_dat = '0;
    repeat (5) @(posedge clk);
    #5;
    rst = 1'b0;
    idle_after_reset();
    seven_word_packet();
    single_word_packet();
    long_packet_overflow();
    random_back_to_back();
    $display("Checks run: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run exceeded %0d cycles", WATCHDOG_CYCLES);
    $display("Checks run: %0d, errors: %0d", n_checks, errors);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
